// ==== soc_mgmt_efuse_wrapper.f ====
src/efuse_pkg.sv
src/efuse_ctrl_if.sv
src/efuse_regs.sv
src/efuse_sequencer.sv
src/efuse_wrapper.sv
src/soc_mgmt_efuse_wrapper.sv
test/tb_soc_mgmt_efuse_wrapper.sv

// ==== Bender.yml ====
package:
  name: soc_mgmt_efuse_wrapper

sources:
  - src/efuse_pkg.sv
  - src/efuse_ctrl_if.sv
  - src/efuse_regs.sv
  - src/efuse_sequencer.sv
  - src/efuse_wrapper.sv
  - src/soc_mgmt_efuse_wrapper.sv
  - target: test
    files:
      - test/tb_soc_mgmt_efuse_wrapper.sv

// ==== test/tb_soc_mgmt_efuse_wrapper.sv ====
////////////////////
// Testbench for the eFUSE subsystem
// Reads are checked against a local fuse image
// Indices come from a 16-bit Galois LFSR, fixed seed
////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_soc_mgmt_efuse_wrapper
  import efuse_pkg::*;
();

  localparam int POLL_LIMIT  = 100;
  localparam int BUSY_WINDOW = 40;
  localparam int NUM_PROG    = 16;
  // Aliases CTRL if only the low address bits were decoded
  localparam logic [REG_ADDR_W-1:0] UNMAPPED_ADDR = 4'hC;

  logic                    clk;
  logic                    rst_n;
  logic                    reg_wr;
  logic                    reg_rd;
  logic [REG_ADDR_W-1:0]   reg_addr;
  logic [REG_DATA_W-1:0]   reg_wdata;
  wire  [REG_DATA_W-1:0]   reg_rdata;
  logic                    vddrdy;
  logic                    vqps_drv;
  wire                     io_efuse_vqps;
  wire                     io_efuse_vddwl;
  // Expected fuse contents
  logic [EFUSE_DATA_W-1:0] ref_img [EFUSE_NUM_WORDS];
  logic [15:0]             lfsr_q;

  assign io_efuse_vqps  = vqps_drv;
  assign io_efuse_vddwl = 1'b1;

  soc_mgmt_efuse_wrapper soc_mgmt_efuse_wrapper_inst (
    .i_clk          (clk),
    .i_rst_n        (rst_n),
    .i_reg_wr       (reg_wr),
    .i_reg_rd       (reg_rd),
    .i_reg_addr     (reg_addr),
    .i_reg_wdata    (reg_wdata),
    .o_reg_rdata    (reg_rdata),
    .i_vddrdy       (vddrdy),
    .io_efuse_vqps  (io_efuse_vqps),
    .io_efuse_vddwl (io_efuse_vddwl)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic write_reg(input logic [REG_ADDR_W-1:0] addr,
                           input logic [REG_DATA_W-1:0] data);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    next_cycle();
    reg_wr = 1'b0;
  endtask

  // Data is registered on the edge that ends the read cycle
  task automatic read_reg(input logic [REG_ADDR_W-1:0] addr,
                          output logic [REG_DATA_W-1:0] data);
    reg_rd   = 1'b1;
    reg_addr = addr;
    next_cycle();
    reg_rd = 1'b0;
    data   = reg_rdata;
  endtask

  task automatic compare(input string name, input logic [REG_DATA_W-1:0] exp,
                         input logic [REG_DATA_W-1:0] act);
    assert (act === exp)
      else stop_on_error($sformatf("Fail at %0t ns: %s expected %h got %h",
                                   $time, name, exp, act));
  endtask

  // Taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      val    = (val << 1) | lfsr_q[0];
    end
  endtask

  function automatic logic [REG_DATA_W-1:0] ctrl_word(input int word, input int bit_idx,
                                                     input logic prog);
    logic [REG_DATA_W-1:0] w;
    w = '0;
    w[CTRL_ADDR_LSB +: EFUSE_ADDR_W] = {word[EFUSE_WORD_W-1:0], bit_idx[EFUSE_BIT_W-1:0]};
    w[prog ? CTRL_PGM_BIT : CTRL_RD_BIT] = 1'b1;
    return w;
  endfunction

  function automatic logic [REG_DATA_W-1:0] status_val(input logic busy, input logic err);
    logic [REG_DATA_W-1:0] s;
    s = '0;
    s[STATUS_BUSY_BIT] = busy;
    s[STATUS_DONE_BIT] = !busy;
    s[STATUS_ERR_BIT]  = err;
    return s;
  endfunction

  // Finished means busy low and done set
  task automatic wait_done(output logic [REG_DATA_W-1:0] status);
    int polls;
    polls = 0;
    read_reg(REG_STATUS, status);
    while (status[STATUS_BUSY_BIT] || !status[STATUS_DONE_BIT]) begin
      polls++;
      if (polls > POLL_LIMIT) begin
        stop_on_error("Timeout: STATUS never showed busy low with done set");
      end
      read_reg(REG_STATUS, status);
    end
  endtask

  task automatic run_cmd(input int word, input int bit_idx, input logic prog,
                         output logic [REG_DATA_W-1:0] status);
    write_reg(REG_CTRL, ctrl_word(word, bit_idx, prog));
    // Start pulse needs one cycle to reach the sequencer
    next_cycle();
    wait_done(status);
  endtask

  task automatic check_rdata(input int word);
    logic [REG_DATA_W-1:0] lo;
    logic [REG_DATA_W-1:0] hi;
    read_reg(REG_RDATA_LO, lo);
    read_reg(REG_RDATA_HI, hi);
    compare($sformatf("RDATA_LO word %0d", word), ref_img[word][31:0], lo);
    compare($sformatf("RDATA_HI word %0d", word), REG_DATA_W'(ref_img[word][39:32]), hi);
  endtask

  task automatic check_word(input int word);
    logic [REG_DATA_W-1:0] status;
    run_cmd(word, 0, 1'b0, status);
    compare("STATUS", status_val(1'b0, 1'b0), status);
    check_rdata(word);
  endtask

  task automatic program_bit(input int word, input int bit_idx);
    logic [REG_DATA_W-1:0] status;
    logic                  bad;
    bad = (bit_idx >= EFUSE_DATA_W);
    run_cmd(word, bit_idx, 1'b1, status);
    compare("STATUS", status_val(1'b0, bad), status);
    // Fuse only blows for a real bit with the program supply up
    if (!bad && vqps_drv) begin
      ref_img[word][bit_idx] = 1'b1;
    end
  endtask

  task automatic pick_clear_pair(output int word, output int bit_idx);
    for (int tries = 0; tries < 16; tries++) begin
      take_bits(EFUSE_WORD_W, word);
      take_bits(EFUSE_BIT_W, bit_idx);
      bit_idx = bit_idx % EFUSE_DATA_W;
      if (!ref_img[word][bit_idx]) begin
        return;
      end
    end
    stop_on_error("LFSR found no unprogrammed fuse bit");
  endtask

  initial begin : stimulus
    logic [REG_DATA_W-1:0] status;
    logic [REG_DATA_W-1:0] rdata;
    int                    word;
    int                    bit_idx;
    int                    word_b;
    int                    bit_b;
    rst_n     = 1'b0;
    reg_wr    = 1'b0;
    reg_rd    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    vddrdy    = 1'b1;
    vqps_drv  = 1'b0;
    lfsr_q    = 16'd55939;
    for (int i = 0; i < EFUSE_NUM_WORDS; i++) begin
      ref_img[i] = '0;
    end
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    next_cycle();

    // Idle status, then a virgin word
    read_reg(REG_STATUS, status);
    compare("STATUS", '0, status);
    take_bits(EFUSE_WORD_W, word);
    check_word(word);

    // CTRL reads back the address of the last command
    read_reg(REG_CTRL, rdata);
    compare("CTRL", REG_DATA_W'(word) << (CTRL_ADDR_LSB + EFUSE_BIT_W), rdata);

    // Unmapped address reads zero and a write there starts nothing
    read_reg(UNMAPPED_ADDR, rdata);
    compare("unmapped register", '0, rdata);
    write_reg(UNMAPPED_ADDR, ctrl_word(word, 0, 1'b0));
    next_cycle();
    read_reg(REG_STATUS, status);
    compare("STATUS", status_val(1'b0, 1'b0), status);

    // Few words so that bits pile up in each
    vqps_drv = 1'b1;
    for (int i = 0; i < NUM_PROG; i++) begin
      take_bits(3, word);
      take_bits(EFUSE_BIT_W, bit_idx);
      program_bit(word, bit_idx % EFUSE_DATA_W);
    end
    for (int w = 0; w < 8; w++) begin
      check_word(w);
    end

    // Supply down
    vqps_drv = 1'b0;
    pick_clear_pair(word, bit_idx);
    program_bit(word, bit_idx);
    check_word(word);

    // Bit index 40..63
    vqps_drv = 1'b1;
    take_bits(EFUSE_WORD_W, word);
    take_bits(5, bit_idx);
    program_bit(word, EFUSE_DATA_W + bit_idx % 24);
    check_word(word);

    // Same fuse twice
    pick_clear_pair(word, bit_idx);
    program_bit(word, bit_idx);
    program_bit(word, bit_idx);
    check_word(word);

    // Second start lands while the first program is running
    pick_clear_pair(word, bit_idx);
    write_reg(REG_CTRL, ctrl_word(word, bit_idx, 1'b1));
    next_cycle();
    read_reg(REG_STATUS, status);
    compare("STATUS busy", 1, status[STATUS_BUSY_BIT]);
    ref_img[word][bit_idx] = 1'b1;
    pick_clear_pair(word_b, bit_b);
    write_reg(REG_CTRL, ctrl_word(word_b, bit_b, 1'b1));
    wait_done(status);
    compare("STATUS", status_val(1'b0, 1'b0), status);
    check_word(word);
    check_word(word_b);

    // Read stalls until vddrdy
    take_bits(3, word);
    vddrdy = 1'b0;
    write_reg(REG_CTRL, ctrl_word(word, 0, 1'b0));
    next_cycle();
    for (int i = 0; i < BUSY_WINDOW; i++) begin
      read_reg(REG_STATUS, status);
      compare("STATUS busy", 1, status[STATUS_BUSY_BIT]);
    end
    vddrdy = 1'b1;
    wait_done(status);
    compare("STATUS", status_val(1'b0, 1'b0), status);
    check_rdata(word);

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/soc_mgmt_efuse_wrapper.sv ====
////////////////////
// eFUSE subsystem top level
// No handshake on the register port; poll STATUS for done
// io_efuse_vqps must be high for programming to take effect
////////////////////
`timescale 1ns/1ps
`default_nettype none

module soc_mgmt_efuse_wrapper
  import efuse_pkg::*;
(
  input  wire                   i_clk,
  input  wire                   i_rst_n,
  input  wire                   i_reg_wr,
  input  wire                   i_reg_rd,
  input  wire  [REG_ADDR_W-1:0] i_reg_addr,
  input  wire  [REG_DATA_W-1:0] i_reg_wdata,
  output logic [REG_DATA_W-1:0] o_reg_rdata,
  // Macro supply ready
  input  wire                   i_vddrdy,
  // Analog supplies, passed straight to the macro
  inout  wire                   io_efuse_vqps,
  inout  wire                   io_efuse_vddwl
);

  // Macro pins
  logic                    efuse_csb;
  logic                    efuse_load;
  logic                    efuse_pgenb;
  logic                    efuse_strobe;
  logic [EFUSE_ADDR_W-1:0] efuse_a;
  logic [EFUSE_DATA_W-1:0] efuse_q;

  efuse_ctrl_if ctrl_if ();

  efuse_regs u_efuse_regs (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_reg_wr    (i_reg_wr),
    .i_reg_rd    (i_reg_rd),
    .i_reg_addr  (i_reg_addr),
    .i_reg_wdata (i_reg_wdata),
    .o_reg_rdata (o_reg_rdata),
    .ctrl        (ctrl_if.regs)
  );

  efuse_sequencer u_efuse_sequencer (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_efuse_vddrdy (i_vddrdy),
    .i_efuse_q      (efuse_q),
    .ctrl           (ctrl_if.seq),
    .o_efuse_csb    (efuse_csb),
    .o_efuse_load   (efuse_load),
    .o_efuse_pgenb  (efuse_pgenb),
    .o_efuse_strobe (efuse_strobe),
    .o_efuse_a      (efuse_a)
  );

  efuse_wrapper u_efuse_wrapper (
    .i_efuse_csb    (efuse_csb),
    .i_efuse_strobe (efuse_strobe),
    .i_efuse_load   (efuse_load),
    .i_efuse_pgenb  (efuse_pgenb),
    .i_efuse_a      (efuse_a),
    .o_efuse_q      (efuse_q),
    .io_efuse_vqps  (io_efuse_vqps),
    .io_efuse_vddwl (io_efuse_vddwl)
  );

endmodule

`default_nettype wire

// ==== src/efuse_wrapper.sv ====
////////////////////
// Behavioral stand-in for the OTP fuse macro
// Array starts all zero; bits only ever go 0 to 1
// Programming needs io_efuse_vqps at 1; pulse width not checked
////////////////////
`timescale 1ns/1ps
`default_nettype none

module efuse_wrapper
  import efuse_pkg::*;
(
  input  wire                     i_efuse_csb,
  input  wire                     i_efuse_strobe,
  input  wire                     i_efuse_load,
  input  wire                     i_efuse_pgenb,
  input  wire  [EFUSE_ADDR_W-1:0] i_efuse_a,
  output logic [EFUSE_DATA_W-1:0] o_efuse_q,
  // Program supply, sampled as a logic level
  inout  wire                     io_efuse_vqps,
  // Wordline supply, not modeled
  inout  wire                     io_efuse_vddwl
);

  logic [EFUSE_DATA_W-1:0] fuse_mem [EFUSE_NUM_WORDS];
  logic [EFUSE_WORD_W-1:0] word_idx;
  logic [EFUSE_BIT_W-1:0]  bit_idx;
  logic [EFUSE_DATA_W-1:0] bit_mask;

  assign word_idx = i_efuse_a[EFUSE_ADDR_W-1:EFUSE_BIT_W];
  assign bit_idx  = i_efuse_a[EFUSE_BIT_W-1:0];

  // One-hot mask, indices past the word shift out to zero
  assign bit_mask = EFUSE_DATA_W'(1) << bit_idx;

  // Virgin array
  initial begin
    for (int i = 0; i < EFUSE_NUM_WORDS; i++) begin
      fuse_mem[i] = '0;
    end
    o_efuse_q = '0;
  end

  // Macro has no clock, everything happens on the strobe edge
  always @(posedge i_efuse_strobe) begin
    if (!i_efuse_csb) begin
      if (i_efuse_load && i_efuse_pgenb) begin
        // Read whole word, bit field ignored
        o_efuse_q <= fuse_mem[word_idx];
      end else if (!i_efuse_pgenb && (io_efuse_vqps == 1'b1)) begin
        // Blow one fuse
        fuse_mem[word_idx] <= fuse_mem[word_idx] | bit_mask;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/efuse_sequencer.sv ====
////////////////////
// Read and program cycle generator for the fuse macro
// Waits for efuse_vddrdy without timeout
// Program bit index above 39 ends in error, no strobe
////////////////////
`timescale 1ns/1ps
`default_nettype none

module efuse_sequencer
  import efuse_pkg::*;
(
  input  wire                     i_clk,
  input  wire                     i_rst_n,
  input  wire                     i_efuse_vddrdy,
  input  wire  [EFUSE_DATA_W-1:0] i_efuse_q,
  efuse_ctrl_if.seq               ctrl,
  output logic                    o_efuse_csb,
  output logic                    o_efuse_load,
  output logic                    o_efuse_pgenb,
  output logic                    o_efuse_strobe,
  output logic [EFUSE_ADDR_W-1:0] o_efuse_a
);

  logic [SEQ_STATE_W-1:0]  state_q;
  logic [SEQ_STATE_W-1:0]  state_d;
  logic [EFUSE_CNT_W-1:0]  cnt_q;
  logic [EFUSE_CNT_W-1:0]  cnt_d;
  logic                    accept;
  logic                    is_prog_q;
  logic [EFUSE_ADDR_W-1:0] addr_q;
  logic                    bit_bad;
  logic                    active_d;
  logic [EFUSE_DATA_W-1:0] rdata_q;

  // Starts only count in idle
  assign accept = (state_q == SEQ_IDLE) && (ctrl.start_read || ctrl.start_prog);

  // Out-of-range bit on a program
  assign bit_bad = is_prog_q && (addr_q[EFUSE_BIT_W-1:0] > EFUSE_MAX_BIT);

  // Next state and cycle counter
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      SEQ_IDLE: begin
        if (accept) begin
          state_d = SEQ_WAIT;
        end
      end
      SEQ_WAIT: begin
        if (bit_bad) begin
          state_d = SEQ_FINISH;
        end else if (i_efuse_vddrdy) begin
          state_d = SEQ_SETUP;
          cnt_d   = EFUSE_SETUP_CYCLES - 1'b1;
        end
      end
      SEQ_SETUP: begin
        if (cnt_q == '0) begin
          state_d = SEQ_STROBE;
          cnt_d   = is_prog_q ? (EFUSE_PGM_STROBE_CYCLES - 1'b1)
                              : (EFUSE_RD_STROBE_CYCLES - 1'b1);
        end else begin
          cnt_d = cnt_q - 1'b1;
        end
      end
      SEQ_STROBE: begin
        if (cnt_q == '0) begin
          state_d = SEQ_HOLD;
          cnt_d   = EFUSE_HOLD_CYCLES - 1'b1;
        end else begin
          cnt_d = cnt_q - 1'b1;
        end
      end
      SEQ_HOLD: begin
        if (cnt_q == '0) begin
          state_d = SEQ_FINISH;
        end else begin
          cnt_d = cnt_q - 1'b1;
        end
      end
      // Single done cycle
      SEQ_FINISH: state_d = SEQ_IDLE;
      default:    state_d = SEQ_IDLE;
    endcase
  end

  // Macro is selected from setup through hold
  assign active_d = (state_d == SEQ_SETUP) || (state_d == SEQ_STROBE) ||
                    (state_d == SEQ_HOLD);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q        <= SEQ_IDLE;
      cnt_q          <= '0;
      is_prog_q      <= 1'b0;
      o_efuse_csb    <= 1'b1;
      o_efuse_load   <= 1'b0;
      o_efuse_pgenb  <= 1'b1;
      o_efuse_strobe <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      // Read wins if both strobes come together
      if (accept) begin
        is_prog_q <= ctrl.start_prog && !ctrl.start_read;
      end
      // Pins registered from next state, glitch free strobe
      o_efuse_csb    <= !active_d;
      o_efuse_load   <= active_d && !is_prog_q;
      o_efuse_pgenb  <= !(active_d && is_prog_q);
      o_efuse_strobe <= (state_d == SEQ_STROBE);
    end
  end

  // Address latched at accept, stable for the whole cycle
  always_ff @(posedge i_clk) begin
    if (accept) begin
      addr_q <= ctrl.addr;
    end
  end

  // Capture q on the edge that drops the strobe
  always_ff @(posedge i_clk) begin
    if ((state_q == SEQ_STROBE) && (cnt_q == '0) && !is_prog_q) begin
      rdata_q <= i_efuse_q;
    end
  end

  assign o_efuse_a  = addr_q;
  assign ctrl.busy  = (state_q != SEQ_IDLE);
  assign ctrl.done  = (state_q == SEQ_FINISH);
  assign ctrl.error = (state_q == SEQ_FINISH) && bit_bad;
  assign ctrl.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== src/efuse_regs.sv ====
////////////////////
// Register block, no bus handshake
// Reads return the register one clock after i_reg_rd
// Unmapped addresses read zero, writes to them are dropped
////////////////////
`timescale 1ns/1ps
`default_nettype none

module efuse_regs
  import efuse_pkg::*;
(
  input  wire                   i_clk,
  input  wire                   i_rst_n,
  input  wire                   i_reg_wr,
  input  wire                   i_reg_rd,
  input  wire  [REG_ADDR_W-1:0] i_reg_addr,
  input  wire  [REG_DATA_W-1:0] i_reg_wdata,
  output logic [REG_DATA_W-1:0] o_reg_rdata,
  efuse_ctrl_if.regs            ctrl
);

  logic                    ctrl_wr;
  logic                    start_read_q;
  logic                    start_prog_q;
  logic [EFUSE_ADDR_W-1:0] addr_q;
  logic                    done_q;
  logic                    error_q;
  logic [EFUSE_DATA_W-1:0] rdata_q;
  logic [REG_DATA_W-1:0]   rd_mux;

  assign ctrl_wr = i_reg_wr && (i_reg_addr == REG_CTRL);

  // Start pulses, one cycle after the CTRL write
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      start_read_q <= 1'b0;
      start_prog_q <= 1'b0;
    end else begin
      start_read_q <= ctrl_wr && i_reg_wdata[CTRL_RD_BIT];
      start_prog_q <= ctrl_wr && i_reg_wdata[CTRL_PGM_BIT];
    end
  end

  // Address field of CTRL
  always_ff @(posedge i_clk) begin
    if (ctrl_wr) begin
      addr_q <= i_reg_wdata[CTRL_ADDR_LSB +: EFUSE_ADDR_W];
    end
  end

  assign ctrl.start_read = start_read_q;
  assign ctrl.start_prog = start_prog_q;
  assign ctrl.addr       = addr_q;

  // Sticky status
  // An accepted start clears it, a dropped start does not
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      done_q  <= 1'b0;
      error_q <= 1'b0;
    end else if (ctrl.done) begin
      done_q  <= 1'b1;
      error_q <= ctrl.error;
    end else if ((start_read_q || start_prog_q) && !ctrl.busy) begin
      done_q  <= 1'b0;
      error_q <= 1'b0;
    end
  end

  // Result word from the sequencer
  always_ff @(posedge i_clk) begin
    if (ctrl.done) begin
      rdata_q <= ctrl.rdata;
    end
  end

  // Read mux
  always_comb begin
    rd_mux = '0;
    case (i_reg_addr)
      REG_CTRL: begin
        rd_mux[CTRL_ADDR_LSB +: EFUSE_ADDR_W] = addr_q;
      end
      REG_STATUS: begin
        rd_mux[STATUS_BUSY_BIT] = ctrl.busy;
        rd_mux[STATUS_DONE_BIT] = done_q;
        rd_mux[STATUS_ERR_BIT]  = error_q;
      end
      REG_RDATA_LO: rd_mux = rdata_q[REG_DATA_W-1:0];
      // Upper fuse bits, zero-extended
      REG_RDATA_HI: rd_mux = REG_DATA_W'(rdata_q[EFUSE_DATA_W-1:REG_DATA_W]);
      default:      rd_mux = '0;
    endcase
  end

  // Read data holds until the next read
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_reg_rdata <= '0;
    end else if (i_reg_rd) begin
      o_reg_rdata <= rd_mux;
    end
  end

endmodule

`default_nettype wire

// ==== src/efuse_ctrl_if.sv ====
////////////////////
// Command and result link, register block to sequencer
// Starts are dropped while busy is high
////////////////////
`timescale 1ns/1ps
`default_nettype none

interface efuse_ctrl_if
  import efuse_pkg::*;
();

  // Commands, one-cycle pulses
  logic                    start_read;
  logic                    start_prog;
  // Macro address, held from the start pulse
  logic [EFUSE_ADDR_W-1:0] addr;

  // Results
  logic                    busy;
  logic                    done;
  // Only valid together with done
  logic                    error;
  logic [EFUSE_DATA_W-1:0] rdata;

  modport regs (
    output start_read, start_prog, addr,
    input  busy, done, error, rdata
  );

  modport seq (
    input  start_read, start_prog, addr,
    output busy, done, error, rdata
  );

endinterface

`default_nettype wire

// ==== src/efuse_pkg.sv ====
////////////////////
// Shared constants for the eFUSE subsystem
// Macro address is {word[7:0], bit[5:0]}; only bits 0..39 exist
// Timing counts are in i_clk cycles and must fit a 4-bit counter
////////////////////
`default_nettype none

package efuse_pkg;

  // Macro address split
  localparam int EFUSE_WORD_W    = 8;
  localparam int EFUSE_BIT_W     = 6;
  localparam int EFUSE_ADDR_W    = EFUSE_WORD_W + EFUSE_BIT_W;
  localparam int EFUSE_DATA_W    = 40;
  localparam int EFUSE_NUM_WORDS = 1 << EFUSE_WORD_W;
  // Highest legal bit index in a word
  localparam logic [EFUSE_BIT_W-1:0] EFUSE_MAX_BIT = EFUSE_BIT_W'(EFUSE_DATA_W - 1);

  // Register port
  localparam int REG_ADDR_W = 4;
  localparam int REG_DATA_W = 32;

  // Register map
  localparam logic [REG_ADDR_W-1:0] REG_CTRL     = 4'd0;
  localparam logic [REG_ADDR_W-1:0] REG_STATUS   = 4'd1;
  localparam logic [REG_ADDR_W-1:0] REG_RDATA_LO = 4'd2;
  localparam logic [REG_ADDR_W-1:0] REG_RDATA_HI = 4'd3;

  // CTRL and STATUS field positions
  localparam int CTRL_RD_BIT     = 0;
  localparam int CTRL_PGM_BIT    = 1;
  localparam int CTRL_ADDR_LSB   = 8;
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;
  localparam int STATUS_ERR_BIT  = 2;

  // Pin timing counts
  localparam int EFUSE_CNT_W = 4;
  localparam logic [EFUSE_CNT_W-1:0] EFUSE_SETUP_CYCLES      = 4'd2;
  localparam logic [EFUSE_CNT_W-1:0] EFUSE_RD_STROBE_CYCLES  = 4'd4;
  localparam logic [EFUSE_CNT_W-1:0] EFUSE_PGM_STROBE_CYCLES = 4'd8;
  localparam logic [EFUSE_CNT_W-1:0] EFUSE_HOLD_CYCLES       = 4'd1;

  // Sequencer state codes
  localparam int SEQ_STATE_W = 3;
  localparam logic [SEQ_STATE_W-1:0] SEQ_IDLE   = 3'd0;
  localparam logic [SEQ_STATE_W-1:0] SEQ_WAIT   = 3'd1;
  localparam logic [SEQ_STATE_W-1:0] SEQ_SETUP  = 3'd2;
  localparam logic [SEQ_STATE_W-1:0] SEQ_STROBE = 3'd3;
  localparam logic [SEQ_STATE_W-1:0] SEQ_HOLD   = 3'd4;
  localparam logic [SEQ_STATE_W-1:0] SEQ_FINISH = 3'd5;

endpackage

`default_nettype wire
